//--- design/fetch_pkg.sv
// --------------------
// fetch package
// PC-mux and exception-mux codes, widths and prefetch sizing
// --------------------

package fetch_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int XLEN        = 32;  // address and instruction width
  localparam int TRAP_BASE_W = 24;  // upper bits of mtvec
  localparam int IRQ_ID_W    = 5;   // vectored interrupt index

  // prefetch buffer entries, also caps requests in flight on the bus
  localparam int FETCH_FIFO_DEPTH = 2;

  // counters run 0..DEPTH, pointers 0..DEPTH-1
  localparam int FIFO_CNT_W = $clog2(FETCH_FIFO_DEPTH + 1);
  localparam int FIFO_PTR_W = $clog2(FETCH_FIFO_DEPTH);

  // --------------------
  // mux selectors
  // --------------------

  // source of the next PC on pc_set
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,  // reset / boot address
    PC_JUMP      = 3'd1,  // jump resolved in ID
    PC_BRANCH    = 3'd2,  // branch resolved in EX
    PC_EXCEPTION = 3'd3,  // trap or interrupt vector
    PC_MRET      = 3'd4,  // return from machine trap
    PC_DRET      = 3'd5,  // return from debug mode
    PC_FENCEI    = 3'd6   // refetch after fence.i
  } pc_mux_e;

  // exception target when PC_EXCEPTION is selected
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,  // synchronous trap, base of mtvec
    EXC_PC_IRQ       = 2'd1,  // vectored interrupt
    EXC_PC_DBD       = 2'd2,  // debug halt request
    EXC_PC_DBE       = 2'd3   // exception while in debug mode
  } exc_pc_mux_e;

endpackage

//--- design/pc_select.sv
// --------------------
// next-PC selector
// picks the fetch target on pc_set, including trap vectors
// --------------------

`timescale 1ns/1ps

module pc_select (
  input  fetch_pkg::pc_mux_e                pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e            exc_pc_mux_i,
  input  logic [fetch_pkg::IRQ_ID_W-1:0]    irq_id_i,
  input  logic [fetch_pkg::TRAP_BASE_W-1:0] trap_base_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]        boot_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]        dm_halt_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]        dm_exception_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]        mepc_i,
  input  logic [fetch_pkg::XLEN-1:0]        depc_i,
  input  logic [fetch_pkg::XLEN-1:0]        jump_target_id_i,
  input  logic [fetch_pkg::XLEN-1:0]        jump_target_ex_i,
  input  logic [fetch_pkg::XLEN-1:0]        pc_id_i,
  output logic [fetch_pkg::XLEN-1:0]        branch_addr_o
);

  import fetch_pkg::*;

  logic [XLEN-1:0] exc_pc;    // trap / debug vector
  logic [XLEN-1:0] next_pc;   // before final word alignment

  // trap vector
  always_comb
  begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXCEPTION: exc_pc = {trap_base_addr_i, 8'h00};                 // common entry
      EXC_PC_IRQ:       exc_pc = {trap_base_addr_i, 1'b0, irq_id_i, 2'b00}; // 4 bytes per irq
      EXC_PC_DBD:       exc_pc = {dm_halt_addr_i[XLEN-1:2], 2'b00};
      EXC_PC_DBE:       exc_pc = {dm_exception_addr_i[XLEN-1:2], 2'b00};
      default:          exc_pc = {trap_base_addr_i, 8'h00};
    endcase
  end

  // next PC source
  always_comb
  begin
    case (pc_mux_i)
      PC_BOOT:      next_pc = boot_addr_i;
      PC_JUMP:      next_pc = jump_target_id_i;
      PC_BRANCH:    next_pc = jump_target_ex_i;
      PC_EXCEPTION: next_pc = exc_pc;
      PC_MRET:      next_pc = mepc_i;              // back to trapped instr
      PC_DRET:      next_pc = depc_i;
      PC_FENCEI:    next_pc = pc_id_i + 32'd4;     // instruction after fence.i
      default:      next_pc = boot_addr_i;         // unused code
    endcase
  end

  // only 32-bit instructions, so the low two bits are always zero
  assign branch_addr_o = {next_pc[XLEN-1:2], 2'b00};

endmodule

//--- design/prefetch_buffer.sv
// --------------------
// prefetch buffer
// sequential word fetch over req/gnt/rvalid, small FIFO of
// word/address pairs, stale responses dropped after a branch
// --------------------

`timescale 1ns/1ps

module prefetch_buffer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_i,          // fetch enable
  input  logic                       branch_i,       // redirect, flush everything
  input  logic [fetch_pkg::XLEN-1:0] branch_addr_i,
  input  logic                       fetch_ready_i,  // IF takes the head word
  output logic                       fetch_valid_o,
  output logic [fetch_pkg::XLEN-1:0] fetch_rdata_o,
  output logic [fetch_pkg::XLEN-1:0] fetch_addr_o,
  output logic                       instr_req_o,
  output logic [fetch_pkg::XLEN-1:0] instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0] instr_rdata_i,
  output logic                       busy_o
);

  import fetch_pkg::*;

  logic [XLEN-1:0]       fetch_addr_q;   // address of the next request
  logic [XLEN-1:0]       rsp_addr_q;     // address of the next kept response
  logic [FIFO_CNT_W-1:0] outstanding_q;  // granted, response still due
  logic [FIFO_CNT_W-1:0] drop_q;         // due responses from before a branch
  logic [FIFO_CNT_W-1:0] fifo_cnt_q;
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;

  logic [XLEN-1:0] fifo_data_q [FETCH_FIFO_DEPTH];
  logic [XLEN-1:0] fifo_addr_q [FETCH_FIFO_DEPTH];

  logic [FIFO_CNT_W:0] inflight;  // one extra bit so the sum cannot wrap
  logic                req_accept;
  logic                rsp_drop;
  logic                rsp_take;
  logic                pop;

  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
    logic [FIFO_PTR_W-1:0] nxt;
    nxt = (ptr == FIFO_PTR_W'(FETCH_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  // --------------------
  // bus side
  // --------------------

  // every slot is either buffered, awaited or about to be dropped
  assign inflight = {1'b0, fifo_cnt_q} + {1'b0, outstanding_q} + {1'b0, drop_q};

  // no request in the branch cycle, the new stream starts one cycle later
  assign instr_req_o  = req_i & ~branch_i & (inflight < (FIFO_CNT_W + 1)'(FETCH_FIFO_DEPTH));
  assign instr_addr_o = fetch_addr_q;
  assign req_accept   = instr_req_o & instr_gnt_i;

  assign rsp_drop = instr_rvalid_i & (drop_q != '0);               // old stream
  assign rsp_take = instr_rvalid_i & (drop_q == '0) & ~branch_i;   // goes into the FIFO

  // --------------------
  // IF side
  // --------------------
  assign fetch_valid_o = (fifo_cnt_q != '0);
  assign fetch_rdata_o = fifo_data_q[rd_ptr_q];
  assign fetch_addr_o  = fifo_addr_q[rd_ptr_q];
  assign pop           = fetch_valid_o & fetch_ready_i;

  assign busy_o = (outstanding_q != '0) | (drop_q != '0);  // bus traffic pending

  // control state
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fetch_addr_q  <= '0;
      rsp_addr_q    <= '0;
      outstanding_q <= '0;
      drop_q        <= '0;
      fifo_cnt_q    <= '0;
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
    end
    else if (branch_i)
    begin
      fetch_addr_q  <= branch_addr_i;
      rsp_addr_q    <= branch_addr_i;
      outstanding_q <= '0;
      // a response in this cycle still belongs to the old stream
      drop_q        <= drop_q + outstanding_q - FIFO_CNT_W'(instr_rvalid_i);
      fifo_cnt_q    <= '0;  // flush
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
    end
    else
    begin
      if (req_accept)
      begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
      if (rsp_take)
      begin
        rsp_addr_q <= rsp_addr_q + 32'd4;
        wr_ptr_q   <= ptr_inc(wr_ptr_q);
      end
      if (pop)
      begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      outstanding_q <= outstanding_q + FIFO_CNT_W'(req_accept) - FIFO_CNT_W'(rsp_take);
      drop_q        <= drop_q - FIFO_CNT_W'(rsp_drop);
      fifo_cnt_q    <= fifo_cnt_q + FIFO_CNT_W'(rsp_take) - FIFO_CNT_W'(pop);
    end
  end

  // FIFO storage
  always_ff @(posedge clk)
  begin
    if (rsp_take)
    begin
      fifo_data_q[wr_ptr_q] <= instr_rdata_i;
      fifo_addr_q[wr_ptr_q] <= rsp_addr_q;
    end
  end

  // --------------------
  // assertions
  // --------------------

  // request throttling must leave a free slot for every kept response
  a_fifo_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    rsp_take |-> (fifo_cnt_q < FIFO_CNT_W'(FETCH_FIFO_DEPTH))
  );

  // held request stays up with its address until granted or redirected
  a_addr_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i && !branch_i)
      |=> ((instr_req_o || branch_i) && $stable(instr_addr_o))
  );

endmodule

//--- design/if_stage.sv
// --------------------
// instruction fetch stage
// next-PC select, prefetch and the IF/ID pipeline registers
// --------------------

`timescale 1ns/1ps

module if_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  // controller side
  input  logic                              req_i,
  input  logic                              pc_set_i,
  input  fetch_pkg::pc_mux_e                pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e            exc_pc_mux_i,
  input  logic [fetch_pkg::IRQ_ID_W-1:0]    irq_id_i,
  input  logic [fetch_pkg::TRAP_BASE_W-1:0] trap_base_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]        boot_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]        dm_halt_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]        dm_exception_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]        mepc_i,
  input  logic [fetch_pkg::XLEN-1:0]        depc_i,
  input  logic [fetch_pkg::XLEN-1:0]        jump_target_id_i,
  input  logic [fetch_pkg::XLEN-1:0]        jump_target_ex_i,
  input  logic                              halt_if_i,
  input  logic                              id_ready_i,
  input  logic                              clear_instr_valid_i,
  // instruction bus
  output logic                              instr_req_o,
  output logic [fetch_pkg::XLEN-1:0]        instr_addr_o,
  input  logic                              instr_gnt_i,
  input  logic                              instr_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0]        instr_rdata_i,
  // to ID
  output logic                              instr_valid_id_o,
  output logic [fetch_pkg::XLEN-1:0]        instr_rdata_id_o,
  output logic [fetch_pkg::XLEN-1:0]        pc_id_o,
  output logic [fetch_pkg::XLEN-1:0]        pc_if_o,
  // status
  output logic                              csr_mtvec_init_o,
  output logic                              if_busy_o,
  output logic                              perf_imiss_o
);

  import fetch_pkg::*;

  logic            branch_req;
  logic [XLEN-1:0] branch_addr;
  logic            fetch_valid;
  logic            fetch_ready;
  logic [XLEN-1:0] fetch_rdata;
  logic [XLEN-1:0] fetch_addr;
  logic            prefetch_busy;
  logic            if_transfer;   // head word moves into IF/ID

  pc_select pc_select_i (
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .irq_id_i            (irq_id_i),
    .trap_base_addr_i    (trap_base_addr_i),
    .boot_addr_i         (boot_addr_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .mepc_i              (mepc_i),
    .depc_i              (depc_i),
    .jump_target_id_i    (jump_target_id_i),
    .jump_target_ex_i    (jump_target_ex_i),
    .pc_id_i             (pc_id_o),
    .branch_addr_o       (branch_addr)
  );

  prefetch_buffer prefetch_buffer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_req),
    .branch_addr_i  (branch_addr),
    .fetch_ready_i  (fetch_ready),
    .fetch_valid_o  (fetch_valid),
    .fetch_rdata_o  (fetch_rdata),
    .fetch_addr_o   (fetch_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (prefetch_busy)
  );

  // --------------------
  // stall / branch control
  // --------------------
  assign branch_req  = pc_set_i;
  // nothing leaves the buffer while ID stalls or a redirect is in flight
  assign fetch_ready = fetch_valid & req_i & id_ready_i & ~halt_if_i & ~branch_req;
  assign if_transfer = fetch_valid & fetch_ready;

  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);  // mtvec init on boot
  assign perf_imiss_o     = ~fetch_valid & ~branch_req;
  assign if_busy_o        = prefetch_busy;
  assign pc_if_o          = fetch_addr;                        // head of the buffer

  // IF/ID valid
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      instr_valid_id_o <= 1'b0;
    end
    else if (if_transfer)
    begin
      instr_valid_id_o <= 1'b1;
    end
    else if (clear_instr_valid_i || branch_req)
    begin
      instr_valid_id_o <= 1'b0;  // killed, word stays but is ignored
    end
  end

  // IF/ID payload, frozen while stalled
  always_ff @(posedge clk)
  begin
    if (if_transfer)
    begin
      instr_rdata_id_o <= fetch_rdata;
      pc_id_o          <= fetch_addr;
    end
  end

  // controller only redirects to a defined source
  a_pc_mux_defined : assert property (
    @(posedge clk) disable iff (!rst_n)
    pc_set_i |-> (pc_mux_i inside {PC_BOOT, PC_JUMP, PC_BRANCH, PC_EXCEPTION,
                                   PC_MRET, PC_DRET, PC_FENCEI})
  );

endmodule

//--- tb/instr_mem_model.sv
// --------------------
// instruction memory model
// grants after 0-2 cycles, answers 1-3 cycles after grant, in order
// --------------------

`timescale 1ns/1ps

module instr_mem_model (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       instr_req_i,
  input  logic [fetch_pkg::XLEN-1:0] instr_addr_i,
  output logic                       instr_gnt_o,
  output logic                       instr_rvalid_o,
  output logic [fetch_pkg::XLEN-1:0] instr_rdata_o
);

  import fetch_pkg::*;

  int unsigned     gnt_wait_q;   // cycles still to wait before the next grant
  int unsigned     cyc_q;        // free running cycle count
  int unsigned     last_due;     // keeps responses in order, one per cycle
  logic [XLEN-1:0] addr_fifo [$];
  int unsigned     due_fifo  [$];

  // word stored at an address: the address with both low bits set
  function automatic logic [XLEN-1:0] rom_word(input logic [XLEN-1:0] addr);
    return addr | 32'h3;
  endfunction

  assign instr_gnt_o = instr_req_i & (gnt_wait_q == 0);

  always @(posedge clk or negedge rst_n)
  begin
    int unsigned due;
    if (!rst_n)
    begin
      gnt_wait_q     <= 0;
      cyc_q          <= 0;
      instr_rvalid_o <= 1'b0;
      instr_rdata_o  <= '0;
      last_due = 0;
      addr_fifo.delete();
      due_fifo.delete();
    end
    else
    begin
      // --------------------
      // grant side
      // --------------------
      if (instr_req_i && instr_gnt_o)
      begin
        due = cyc_q + 1 + ($urandom % 3);  // 1..3 cycles after the grant
        if (due <= last_due)
        begin
          due = last_due + 1;              // never overtake an older word
        end
        last_due = due;
        addr_fifo.push_back(instr_addr_i);
        due_fifo.push_back(due);
        gnt_wait_q <= $urandom % 3;        // delay for the next request
      end
      else if (instr_req_i && gnt_wait_q != 0)
      begin
        gnt_wait_q <= gnt_wait_q - 1;
      end

      // response side, visible in the next cycle
      instr_rvalid_o <= 1'b0;
      if (due_fifo.size() > 0 && due_fifo[0] <= cyc_q + 1)
      begin
        instr_rvalid_o <= 1'b1;
        instr_rdata_o  <= rom_word(addr_fifo.pop_front());
        void'(due_fifo.pop_front());
      end
      cyc_q <= cyc_q + 1;
    end
  end

endmodule

//--- tb/tb_if_stage.sv
// --------------------
// fetch stage testbench
// directed redirects, vectors, stalls and clear against a random-delay memory
// --------------------

`timescale 1ns/1ps

module tb_if_stage;

  import fetch_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;                 // inputs change after the edge
  localparam int WAIT_LIMIT = 20;                 // cycles allowed per instruction
  localparam logic [31:0] SEED = 32'h58ae7608;

  // --------------------
  // run length budget, cycles per test
  // --------------------
  localparam int BOOT_CYC     = 150;
  localparam int FLUSH_CYC    = 400;
  localparam int EXC_CYC      = 600;
  localparam int RET_CYC      = 200;
  localparam int STALL_CYC    = 400;
  localparam int MARGIN_CYC   = 200;
  localparam int WATCHDOG_CYC = BOOT_CYC + FLUSH_CYC + EXC_CYC + RET_CYC + STALL_CYC
                                + MARGIN_CYC;

  // source addresses, some deliberately unaligned
  localparam logic [31:0] BOOT_ADDR = 32'h0000_1082;
  localparam logic [31:0] JUMP_ID   = 32'h0000_2000;
  localparam logic [31:0] JUMP_EX   = 32'h0000_3404;
  localparam logic [31:0] MEPC      = 32'h0000_5009;
  localparam logic [31:0] DEPC      = 32'h0000_6ffc;
  localparam logic [31:0] DM_HALT   = 32'h0000_0803;
  localparam logic [31:0] DM_EXC    = 32'h0000_0a07;
  localparam logic [23:0] TRAP_BASE = 24'h000080;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        pc_set;
  pc_mux_e     pc_mux;
  exc_pc_mux_e exc_pc_mux;
  logic [4:0]  irq_id;
  logic        halt_if;
  logic        id_ready;
  logic        clear_valid;

  logic        instr_req;
  logic [31:0] instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_rdata;
  logic        instr_valid_id;
  logic [31:0] instr_rdata_id;
  logic [31:0] pc_id;
  logic [31:0] pc_if;
  logic        csr_mtvec_init;
  logic        if_busy;
  logic        perf_imiss;

  // monitor state
  logic [31:0] exp_pc;      // PC of the next instruction into ID
  logic [31:0] last_pc;     // PC now held in ID
  logic        have_instr;
  logic        xfer_q;      // a transfer happens at the coming edge
  logic        gnt_q;       // a bus request is accepted at the coming edge
  int          instr_cnt;
  string       test_name;

  if_stage dut_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req),
    .pc_set_i            (pc_set),
    .pc_mux_i            (pc_mux),
    .exc_pc_mux_i        (exc_pc_mux),
    .irq_id_i            (irq_id),
    .trap_base_addr_i    (TRAP_BASE),
    .boot_addr_i         (BOOT_ADDR),
    .dm_halt_addr_i      (DM_HALT),
    .dm_exception_addr_i (DM_EXC),
    .mepc_i              (MEPC),
    .depc_i              (DEPC),
    .jump_target_id_i    (JUMP_ID),
    .jump_target_ex_i    (JUMP_EX),
    .halt_if_i           (halt_if),
    .id_ready_i          (id_ready),
    .clear_instr_valid_i (clear_valid),
    .instr_req_o         (instr_req),
    .instr_addr_o        (instr_addr),
    .instr_gnt_i         (instr_gnt),
    .instr_rvalid_i      (instr_rvalid),
    .instr_rdata_i       (instr_rdata),
    .instr_valid_id_o    (instr_valid_id),
    .instr_rdata_id_o    (instr_rdata_id),
    .pc_id_o             (pc_id),
    .pc_if_o             (pc_if),
    .csr_mtvec_init_o    (csr_mtvec_init),
    .if_busy_o           (if_busy),
    .perf_imiss_o        (perf_imiss)
  );

  instr_mem_model mem_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_gnt_o    (instr_gnt),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    fail_stop("watchdog expired, the run took longer than the tests allow");
  end

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return addr | 32'h3;  // memory contents rule
  endfunction

  function automatic logic [31:0] word_align(input logic [31:0] addr);
    return {addr[31:2], 2'b00};
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string what, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    if (exp_val !== act_val)
    begin
      fail_stop($sformatf("FAIL %s / %s: expected 0x%08h, actual 0x%08h",
                          test_name, what, exp_val, act_val));
    end
  endtask

  // --------------------
  // ID side monitor
  // --------------------
  always @(negedge clk)
  begin
    if (xfer_q)
    begin
      check("id valid", 32'd1, 32'(instr_valid_id));
      check("id pc", exp_pc, pc_id);
      check("id rdata", word_at(exp_pc), instr_rdata_id);
      last_pc    = exp_pc;
      exp_pc     = exp_pc + 32'd4;   // stream stays contiguous
      have_instr = 1'b1;
      instr_cnt++;
    end
    else if (have_instr)
    begin
      check("held pc", last_pc, pc_id);           // frozen while stalled
      check("held rdata", word_at(last_pc), instr_rdata_id);
    end
    if (gnt_q)
    begin
      check("busy after grant", 32'd1, 32'(if_busy));  // its response is still due
    end
    gnt_q = rst_n && instr_req && instr_gnt;
    // head of the buffer moves into ID when valid and nothing holds it
    xfer_q = rst_n && !perf_imiss && req && id_ready && !halt_if && !pc_set;
    if (xfer_q)
    begin
      check("pc_if", exp_pc, pc_if);
    end
  end

  task automatic wait_instrs(input int n);
    int target;
    int waited;
    target = instr_cnt + n;
    waited = 0;
    while (instr_cnt < target)
    begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT * n)
      begin
        fail_stop("timeout while waiting for instructions from the fetch stage");
      end
    end
  endtask

  // one cycle pc_set pulse, then the new stream must start at target
  task automatic redirect(input pc_mux_e mux, input exc_pc_mux_e exc,
                          input logic [4:0] id, input logic [31:0] target);
    @(posedge clk);
    #DRIVE_DLY;
    req        = 1'b1;
    pc_set     = 1'b1;
    pc_mux     = mux;
    exc_pc_mux = exc;
    irq_id     = id;
    @(negedge clk);
    check("mtvec init", 32'(mux == PC_BOOT), 32'(csr_mtvec_init));
    @(posedge clk);
    #DRIVE_DLY;
    pc_set = 1'b0;
    exp_pc = (mux == PC_FENCEI) ? last_pc + 32'd4 : target;  // fence refetches next
    check("valid after redirect", 32'd0, 32'(instr_valid_id));
  endtask

  task automatic test_boot();
    test_name = "boot";
    redirect(PC_BOOT, EXC_PC_EXCEPTION, 5'd0, word_align(BOOT_ADDR));
    wait_instrs(6);
  endtask

  task automatic test_flush();
    test_name = "flush";
    redirect(PC_JUMP, EXC_PC_EXCEPTION, 5'd0, word_align(JUMP_ID));
    wait_instrs(4);
    redirect(PC_BRANCH, EXC_PC_EXCEPTION, 5'd0, word_align(JUMP_EX));
    wait_instrs(4);
    redirect(PC_FENCEI, EXC_PC_EXCEPTION, 5'd0, 32'd0);
    wait_instrs(4);
  endtask

  task automatic test_vectors();
    logic [4:0] ids [4];
    ids = '{5'd0, 5'd1, 5'd17, 5'd31};
    test_name = "vectors";
    redirect(PC_EXCEPTION, EXC_PC_EXCEPTION, 5'd9, {TRAP_BASE, 8'h00});  // index ignored
    wait_instrs(3);
    foreach (ids[k])
    begin
      redirect(PC_EXCEPTION, EXC_PC_IRQ, ids[k], {TRAP_BASE, 1'b0, ids[k], 2'b00});
      wait_instrs(3);
    end
    redirect(PC_EXCEPTION, EXC_PC_DBD, 5'd0, word_align(DM_HALT));
    wait_instrs(3);
    redirect(PC_EXCEPTION, EXC_PC_DBE, 5'd0, word_align(DM_EXC));
    wait_instrs(3);
  endtask

  task automatic test_returns();
    test_name = "returns";
    redirect(PC_MRET, EXC_PC_EXCEPTION, 5'd0, word_align(MEPC));
    wait_instrs(3);
    redirect(PC_DRET, EXC_PC_EXCEPTION, 5'd0, word_align(DEPC));
    wait_instrs(3);
  endtask

  task automatic test_stall();
    int stall_len;
    int run_len;
    int use_halt;
    test_name = "stall";
    for (int s = 0; s < 12; s++)
    begin
      stall_len = 1 + $urandom % 4;
      run_len   = 1 + $urandom % 3;
      use_halt  = $urandom % 2;
      repeat (stall_len)
      begin
        @(posedge clk);
        #DRIVE_DLY;
        halt_if  = (use_halt != 0);
        id_ready = (use_halt == 0);
      end
      repeat (run_len)
      begin
        @(posedge clk);
        #DRIVE_DLY;
        halt_if  = 1'b0;
        id_ready = 1'b1;
      end
    end
    // clear while ID stalls, valid must drop at the next edge
    @(posedge clk);
    #DRIVE_DLY;
    check("valid before clear", 32'd1, 32'(instr_valid_id));
    id_ready    = 1'b0;
    clear_valid = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    clear_valid = 1'b0;
    check("valid after clear", 32'd0, 32'(instr_valid_id));
    @(posedge clk);
    #DRIVE_DLY;
    id_ready = 1'b1;
    wait_instrs(6);
  endtask

  initial
  begin
    void'($urandom(SEED));
    rst_n       = 1'b0;
    req         = 1'b0;   // no fetch until boot
    pc_set      = 1'b0;
    pc_mux      = PC_BOOT;
    exc_pc_mux  = EXC_PC_EXCEPTION;
    irq_id      = '0;
    halt_if     = 1'b0;
    id_ready    = 1'b1;
    clear_valid = 1'b0;
    exp_pc      = '0;
    last_pc     = '0;
    have_instr  = 1'b0;
    xfer_q      = 1'b0;
    gnt_q       = 1'b0;
    instr_cnt   = 0;
    test_name   = "reset";
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    check("instr_req", 32'd0, 32'(instr_req));
    check("valid", 32'd0, 32'(instr_valid_id));
    check("mtvec init", 32'd0, 32'(csr_mtvec_init));
    check("busy", 32'd0, 32'(if_busy));
    rst_n = 1'b1;

    test_boot();
    test_flush();
    test_vectors();
    test_returns();
    test_stall();

    $display("All tests passed");
    $finish;
  end

endmodule

//--- list.f
design/fetch_pkg.sv
design/pc_select.sv
design/prefetch_buffer.sv
design/if_stage.sv
tb/instr_mem_model.sv
tb/tb_if_stage.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_if_stage
RTL_TOP    ?= if_stage
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_MSG   ?= All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
